//--- filelist.f
alphaIsaPkg.sv
memSysPkg.sv
memIssue.sv
memAgu.sv
memAccess.sv
dataRam.sv
memTop.sv
tbMemTop.sv

//--- tbMemTop.sv
`timescale 1ns/1ns
`default_nettype none

module tbMemTop
	import alphaIsaPkg::*;
;

	localparam int ClkHalf   = 2;     // 4 ns period
	localparam int ResetCyc  = 8;
	localparam int SettleCyc = 20;    // Longer than a full drain of all lanes
	// About 60 instructions at under 8 cycles each plus settling, with wide margin
	localparam int TimeoutCycles = 4000;
	localparam logic [DataW-1:0] BurstBase = 64'h200; // Quads used by the random burst

	logic             clk;
	logic             rstN;
	logic             instValid;
	logic             instReady;
	opCodeT           opCode;
	logic [DataW-1:0] op1;
	logic [DataW-1:0] op2;
	logic [DispW-1:0] disp;
	logic             resValid;
	logic [DataW-1:0] resData;

	logic [DataW-1:0] model [int]; // Reference memory, keyed by RAM word
	logic [DataW-1:0] expQ [$];    // Results the model predicts
	logic [DataW-1:0] gotQ [$];    // Results seen at the port
	integer           seed;
	int               cycles;
	int               errCount;
	int               testErr;
	int               testCount;
	int               failCount;

	memTop uut (.clk(clk), .rstN(rstN), .instValid(instValid), .instReady(instReady),
		.opCode(opCode), .op1(op1), .op2(op2), .disp(disp),
		.resValid(resValid), .resData(resData));

	always #ClkHalf clk = ~clk;

	// Results are registered, so the falling edge sees them settled
	always @(negedge clk) begin
		if (rstN && resValid)
			gotQ.push_back(resData);
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TimeoutCycles) begin
			$display("timeout: run did not finish within %0d cycles", TimeoutCycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	// Effective address from base, displacement and opcode
	function automatic logic [DataW-1:0] effAddr(input opCodeT op, input logic [DataW-1:0] b,
		input logic [DispW-1:0] d);
		logic [DataW-1:0] ext;
		logic [DataW-1:0] ea;
		ext = {{(DataW - DispW){d[DispW-1]}}, d};
		if (op == OpLdah)
			ext = ext << 16;
		ea = b + ext;
		if (op == OpLdqU || op == OpStqU)
			ea[2:0] = 3'b000;
		return ea;
	endfunction

	// One instruction over valid/ready, called 1 ns after a rising edge
	task automatic sendInst(input opCodeT op, input logic [DataW-1:0] a,
		input logic [DataW-1:0] b, input logic [DispW-1:0] d);
		logic rdy;
		instValid = 1'b1;
		opCode    = op;
		op1       = a;
		op2       = b;
		disp      = d;
		do begin
			@(negedge clk);
			rdy = instReady; // Cannot change before the next rising edge
			@(posedge clk);
		end while (!rdy);
		#1;
		instValid = 1'b0;
	endtask

	// Update the model and the expected queue, then send
	task automatic runInst(input opCodeT op, input logic [DataW-1:0] a,
		input logic [DataW-1:0] b, input logic [DispW-1:0] d);
		logic [DataW-1:0] ea;
		logic [DataW-1:0] word;
		logic [31:0]      half;
		int               key;
		ea   = effAddr(op, b, d);
		key  = int'(ea[10:3]); // RAM decodes 8 word bits only
		word = model.exists(key) ? model[key] : '0;
		half = ea[2] ? word[63:32] : word[31:0];
		case (op)
			OpLda, OpLdah: expQ.push_back(ea);
			OpLdq, OpLdqU: expQ.push_back(word);
			OpLdl:         expQ.push_back({{32{half[31]}}, half});
			OpStq, OpStqU: model[key] = a;
			OpStl: begin
				if (ea[2])
					word[63:32] = a[31:0];
				else
					word[31:0] = a[31:0];
				model[key] = word;
			end
			default: ; // Dropped by issue, no result
		endcase
		sendInst(op, a, b, d);
	endtask

	// Wait for every predicted result, then look for extra ones
	task automatic checkResults(input string name);
		logic [DataW-1:0] got;
		logic [DataW-1:0] exp;
		int               n;
		while (gotQ.size() < expQ.size())
			@(negedge clk);
		repeat (SettleCyc) @(negedge clk);
		assert (gotQ.size() == expQ.size()) else begin
			$display("%s: got %0d results but expected %0d", name, gotQ.size(), expQ.size());
			testErr++;
		end
		n = 0;
		while (gotQ.size() > 0 && expQ.size() > 0) begin
			got = gotQ.pop_front();
			exp = expQ.pop_front();
			assert (got === exp) else begin
				$display("error: resData result %0d got %h exp %h", n, got, exp);
				testErr++;
			end
			n++;
		end
		gotQ.delete();
		expQ.delete();
		testCount++;
		if (testErr != 0)
			failCount++;
		errCount += testErr;
		$display("test %s: %0d errors", name, testErr);
		testErr = 0;
		@(posedge clk);
		#1;
	endtask

	task automatic testResetState;
		assert (resValid === 1'b0) else begin
			$display("error: resValid got %h exp 0", resValid);
			testErr++;
		end
		assert (instReady === 1'b1) else begin
			$display("error: instReady got %h exp 1", instReady);
			testErr++;
		end
		checkResults("reset state");
	endtask

	task automatic testLdaLdah;
		runInst(OpLda,  64'h0, 64'h1000, 16'h0010);
		runInst(OpLda,  64'h0, 64'h1000, 16'hFFF0); // Negative disp
		runInst(OpLdah, 64'h0, 64'h1234, 16'h0001);
		runInst(OpLdah, 64'h0, 64'h0,    16'h8000); // Negative, scaled
		runInst(OpLda,  64'h0, {$random(seed), $random(seed)}, 16'($random(seed)));
		runInst(OpLdah, 64'h0, {$random(seed), $random(seed)}, 16'($random(seed)));
		checkResults("lda ldah");
	endtask

	task automatic testStqLdq;
		runInst(OpStq, 64'h0123_4567_89AB_CDEF, 64'h100, 16'h0000);
		runInst(OpStq, 64'hFEDC_BA98_7654_3210, 64'h100, 16'h0008);
		runInst(OpLdq, 64'h0, 64'h100, 16'h0000);
		runInst(OpLdq, 64'h0, 64'h108, 16'h0000);
		runInst(OpLdq, 64'h0, 64'h110, 16'hFFF8); // Same quad, other way
		runInst(OpStq, 64'hA5A5_5A5A_0F0F_F0F0, 64'h100, 16'h0000);
		runInst(OpLdq, 64'h0, 64'h100, 16'h0000);
		runInst(OpLdq, 64'h0, 64'h108, 16'h0000); // Untouched neighbour
		checkResults("stq ldq");
	endtask

	task automatic testStlHalves;
		runInst(OpStq, 64'h1111_2222_3333_4444, 64'h180, 16'h0000);
		runInst(OpStl, 64'hDEAD_BEEF_8000_1234, 64'h180, 16'h0000); // Low half
		runInst(OpStl, 64'h0BAD_F00D_0000_5678, 64'h180, 16'h0004); // High half
		runInst(OpLdq, 64'h0, 64'h180, 16'h0000);
		runInst(OpLdl, 64'h0, 64'h180, 16'h0000); // Negative long
		runInst(OpLdl, 64'h0, 64'h184, 16'h0000);
		runInst(OpStl, 64'h0000_0000_F234_5678, 64'h188, 16'hFFFC);
		runInst(OpLdl, 64'h0, 64'h184, 16'h0000);
		runInst(OpLdq, 64'h0, 64'h180, 16'h0000);
		checkResults("stl halves");
	endtask

	task automatic testUnaligned;
		runInst(OpStqU, 64'hCAFE_0000_1234_ABCD, 64'h1C3, 16'h0002); // 0x1C5 down to 0x1C0
		runInst(OpLdqU, 64'h0, 64'h1C7, 16'h0000);
		runInst(OpLdq,  64'h0, 64'h1C0, 16'h0000);
		runInst(OpStqU, 64'h7777_8888_9999_AAAA, 64'h1D0, 16'hFFFD); // 0x1CD down to 0x1C8
		runInst(OpLdqU, 64'h0, 64'h1CA, 16'h0000);
		runInst(OpLdqU, 64'h0, 64'h1C1, 16'h0000);
		checkResults("unaligned");
	endtask

	task automatic testRandomBurst;
		logic [DataW-1:0] dat;
		logic [DataW-1:0] base;
		logic [DispW-1:0] d;
		int               kind;
		for (int i = 0; i < 8; i++)
			runInst(OpStq, {$random(seed), $random(seed)}, BurstBase + 64'(8 * i), 16'h0);
		for (int n = 0; n < 20; n++) begin
			kind = $unsigned($random(seed)) % 8;
			dat  = {$random(seed), $random(seed)};
			base = BurstBase + 64'(8 * ($unsigned($random(seed)) % 8));
			d    = 16'($unsigned($random(seed)) % 8); // Stays inside the quad
			if ($random(seed) & 1)
				runInst(opCodeT'(6'h10), dat, base, d); // Integer op, dropped
			case (kind)
				0: runInst(OpLda,  dat, base, d);
				1: runInst(OpLdah, dat, base, d);
				2: runInst(OpLdq,  dat, base, d);
				3: runInst(OpLdl,  dat, base, d);
				4: runInst(OpLdqU, dat, base, d);
				5: runInst(OpStq,  dat, base, d);
				6: runInst(OpStl,  dat, base, d);
				default: runInst(OpStqU, dat, base, d);
			endcase
		end
		checkResults("random burst");
	endtask

	initial begin
		clk       = 1'b0;
		rstN      = 1'b0;
		instValid = 1'b0;
		opCode    = OpLda;
		op1       = '0;
		op2       = '0;
		disp      = '0;
		seed      = 43;
		cycles    = 0;
		errCount  = 0;
		testErr   = 0;
		testCount = 0;
		failCount = 0;
		repeat (ResetCyc) @(posedge clk);
		#1;
		rstN = 1'b1;
		testResetState(); // Before any instruction
		testLdaLdah();
		testStqLdq();
		testStlHalves();
		testUnaligned();
		testRandomBurst();
		$display("tests %0d, failed %0d, errors %0d", testCount, failCount, errCount);
		if (errCount == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire

//--- memTop.sv
`timescale 1ns/1ns
`default_nettype none

module memTop
	import alphaIsaPkg::*;
	import memSysPkg::*;
(
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire logic             instValid,
	output logic                  instReady,
	input  wire opCodeT           opCode,
	input  wire logic [DataW-1:0] op1,
	input  wire logic [DataW-1:0] op2,
	input  wire logic [DispW-1:0] disp,
	output logic                  resValid,
	output logic [DataW-1:0]      resData
);

	logic [NumLanes-1:0] laneBusy;
	logic [NumLanes-1:0] laneLoad;   // Per-lane dispatch strobes
	opCodeT              laneOpCode;
	logic [DataW-1:0]    laneOp1;
	logic [DataW-1:0]    laneOp2;
	logic [DispW-1:0]    laneDisp;

	logic [NumLanes-1:0] aguValid;
	logic [NumLanes-1:0] aguTake;
	opCodeT              aguOpCode [NumLanes];
	logic [DataW-1:0]    aguResData [NumLanes];
	logic [DataW-1:0]    aguResAdr [NumLanes];

	logic                wbCyc;
	logic                wbStb;
	logic                wbWe;
	logic                wbAck;
	logic [WbAw-1:0]     wbAdr;
	logic [SelW-1:0]     wbSel;
	logic [DataW-1:0]    wbDatW;
	logic [DataW-1:0]    wbDatR;

	memIssue uIssue (.clk, .rstN, .instValid, .instReady, .opCode, .op1, .op2, .disp,
		.laneBusy, .laneLoad, .laneOpCode, .laneOp1, .laneOp2, .laneDisp);

	// One slot per lane, all fed from the shared issue lines
	for (genvar i = 0; i < NumLanes; i++) begin : genLane
		memAgu uAgu (.clk, .rstN, .load(laneLoad[i]), .opCode(laneOpCode),
			.op1(laneOp1), .op2(laneOp2), .disp(laneDisp), .take(aguTake[i]),
			.busy(laneBusy[i]), .aguValid(aguValid[i]), .aguOpCode(aguOpCode[i]),
			.aguResData(aguResData[i]), .aguResAdr(aguResAdr[i]));
	end

	memAccess uAccess (.clk, .rstN, .aguValid, .aguOpCode, .aguResData, .aguResAdr,
		.aguTake, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbSel, .wbDatW, .wbAck, .wbDatR,
		.resValid, .resData);

	dataRam uRam (.clk, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbSel, .wbDatW,
		.wbAck, .wbDatR);

endmodule

`default_nettype wire

//--- dataRam.sv
`timescale 1ns/1ns
`default_nettype none

module dataRam
	import alphaIsaPkg::*;
	import memSysPkg::*;
(
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire logic             wbCyc,
	input  wire logic             wbStb,
	input  wire logic             wbWe,
	input  wire logic [WbAw-1:0]  wbAdr,
	input  wire logic [SelW-1:0]  wbSel,
	input  wire logic [DataW-1:0] wbDatW,
	output logic                  wbAck,
	output logic [DataW-1:0]      wbDatR
);

	logic [DataW-1:0] mem [RamWords];
	logic [RamAw-1:0] wordAdr;
	logic             hit;     // Fresh request, not yet acked

	// Byte offset comes in through wbSel, upper bits wrap
	assign wordAdr = wbAdr[RamAw+2:3];
	assign hit     = wbCyc && wbStb && !wbAck;

	// Registered ack, one cycle after strobe
	always_ff @(posedge clk) begin
		if (!rstN)
			wbAck <= 1'b0;
		else
			wbAck <= hit;
	end

	always_ff @(posedge clk) begin
		if (hit) begin
			if (wbWe) begin
				for (int b = 0; b < SelW; b++) begin
					if (wbSel[b])
						mem[wordAdr][8*b +: 8] <= wbDatW[8*b +: 8]; // Masked byte write
				end
			end
			wbDatR <= mem[wordAdr]; // Old data on a write
		end
	end

	// Ack only answers a live strobe
	assert property (@(posedge clk) disable iff (!rstN) wbAck |-> wbStb);

endmodule

`default_nettype wire

//--- memAccess.sv
`timescale 1ns/1ns
`default_nettype none

module memAccess
	import alphaIsaPkg::*;
	import memSysPkg::*;
(
	input  wire logic                clk,
	input  wire logic                rstN,
	input  wire logic [NumLanes-1:0] aguValid,
	input  wire opCodeT              aguOpCode [NumLanes],
	input  wire logic [DataW-1:0]    aguResData [NumLanes],
	input  wire logic [DataW-1:0]    aguResAdr [NumLanes],
	output logic [NumLanes-1:0]      aguTake,
	output logic                     wbCyc,
	output logic                     wbStb,
	output logic                     wbWe,
	output logic [WbAw-1:0]          wbAdr,
	output logic [SelW-1:0]          wbSel,
	output logic [DataW-1:0]         wbDatW,
	input  wire logic                wbAck,
	input  wire logic [DataW-1:0]    wbDatR,
	output logic                     resValid,
	output logic                     [DataW-1:0] resData
);

	busStateT         state;
	logic [LaneW-1:0] curLane; // Oldest lane, served next
	opCodeT           opR;     // Op on the bus
	opCodeT           laneOp;
	logic [DataW-1:0] laneAdr;
	logic [DataW-1:0] laneDat;
	logic             start;   // Slot captured at this edge
	logic [SelW-1:0]  stSel;
	logic [DataW-1:0] stDat;
	logic [LongW-1:0] ldLong;  // Addressed half of the read word
	logic [DataW-1:0] ldDat;

	assign laneOp  = aguOpCode[curLane];
	assign laneAdr = aguResAdr[curLane];
	assign laneDat = aguResData[curLane];
	assign start   = (state == Idle) && aguValid[curLane];

	// Longword stores land in the half picked by bit 2
	always_comb begin
		if (isLong(laneOp)) begin
			stSel = laneAdr[2] ? SelW'(8'hF0) : SelW'(8'h0F);
			stDat = laneAdr[2] ? {laneDat[LongW-1:0], {LongW{1'b0}}}
				: {{LongW{1'b0}}, laneDat[LongW-1:0]};
		end else begin
			stSel = '1; // Whole quad
			stDat = laneDat;
		end
	end

	// LDL sign-extends its half, quad loads pass through
	always_comb begin
		ldLong = wbAdr[2] ? wbDatR[DataW-1:LongW] : wbDatR[LongW-1:0];
		ldDat  = isLong(opR) ? {{(DataW - LongW){ldLong[LongW-1]}}, ldLong} : wbDatR;
	end

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state    <= Idle;
			curLane  <= '0;
			aguTake  <= '0;
			wbCyc    <= 1'b0;
			wbStb    <= 1'b0;
			resValid <= 1'b0;
		end else begin
			aguTake  <= '0;   // Single-cycle pulses
			resValid <= 1'b0;
			case (state)
				Idle: begin
					if (start) begin
						aguTake[curLane] <= 1'b1; // Frees the slot next edge
						curLane <= (curLane == LaneW'(NumLanes - 1)) ? '0 : curLane + 1'b1;
						if (isAddrOnly(laneOp)) begin
							state <= Emit;
						end else begin
							state <= Bus;
							wbCyc <= 1'b1;
							wbStb <= 1'b1;
						end
					end
				end
				Bus: begin
					if (wbAck) begin
						wbCyc    <= 1'b0;
						wbStb    <= 1'b0;
						resValid <= !isStore(opR); // Stores end silently
						state    <= Idle;
					end
				end
				Emit: begin
					resValid <= 1'b1;
					state    <= Idle;
				end
				default: state <= Idle;
			endcase
		end
	end

	// Bus payload and result data
	always_ff @(posedge clk) begin
		if (start) begin
			opR     <= laneOp;
			wbWe    <= isStore(laneOp);
			wbAdr   <= laneAdr[WbAw-1:0];
			wbSel   <= stSel;
			wbDatW  <= stDat;
			resData <= laneDat; // LDA/LDAH result
		end else if (state == Bus && wbAck) begin
			resData <= ldDat;
		end
	end

	// Strobe never outside a bus cycle
	assert property (@(posedge clk) disable iff (!rstN) wbStb |-> wbCyc);

endmodule

`default_nettype wire

//--- memAgu.sv
`timescale 1ns/1ns
`default_nettype none

module memAgu
	import alphaIsaPkg::*;
(
	input  wire logic             clk,
	input  wire logic             rstN,
	input  wire logic             load,
	input  wire opCodeT           opCode,
	input  wire logic [DataW-1:0] op1,
	input  wire logic [DataW-1:0] op2,
	input  wire logic [DispW-1:0] disp,
	input  wire logic             take,
	output logic                  busy,
	output logic                  aguValid,
	output opCodeT                aguOpCode,
	output logic [DataW-1:0]      aguResData,
	output logic [DataW-1:0]      aguResAdr
);

	logic             full;    // Slot occupied
	logic [DataW-1:0] op1R;    // Store data
	logic [DataW-1:0] op2R;    // Base register
	logic [DispW-1:0] dispR;
	logic [DataW-1:0] dispExt; // Sign-extended displacement
	logic [DataW-1:0] offset;
	logic [DataW-1:0] sum;     // Effective address or LDA result

	// Slot flag, filled by issue and emptied by access
	always_ff @(posedge clk) begin
		if (!rstN)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;
		else if (take)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (load) begin
			aguOpCode <= opCode;
			op1R      <= op1;
			op2R      <= op2;
			dispR     <= disp;
		end
	end

	always_comb begin
		dispExt = {{(DataW - DispW){dispR[DispW-1]}}, dispR};
		offset  = (aguOpCode == OpLdah) ? dispExt << DispW : dispExt; // LDAH scales by 64K
		sum     = op2R + offset;
		if (aguOpCode == OpLdqU || aguOpCode == OpStqU)
			sum[2:0] = 3'b000; // Quad-align the unaligned forms

		// Output mux
		if (isAddrOnly(aguOpCode)) begin
			aguResData = sum; // Goes straight to the result port
			aguResAdr  = '0;
		end else begin
			aguResData = op1R; // Store data, ignored by loads
			aguResAdr  = sum;
		end
	end

	assign busy     = full;
	assign aguValid = full;

	// Issue only targets an empty slot
	assert property (@(posedge clk) disable iff (!rstN) load |-> !full);

	// Access only takes a filled slot, never in the load cycle
	assert property (@(posedge clk) disable iff (!rstN) take |-> full && !load);

endmodule

`default_nettype wire

//--- memIssue.sv
`timescale 1ns/1ns
`default_nettype none

module memIssue
	import alphaIsaPkg::*;
	import memSysPkg::*;
(
	input  wire logic                clk,
	input  wire logic                rstN,
	input  wire logic                instValid,
	output logic                     instReady,
	input  wire opCodeT              opCode,
	input  wire logic [DataW-1:0]    op1,
	input  wire logic [DataW-1:0]    op2,
	input  wire logic [DispW-1:0]    disp,
	input  wire logic [NumLanes-1:0] laneBusy,
	output logic [NumLanes-1:0]      laneLoad,
	output opCodeT                   laneOpCode,
	output logic [DataW-1:0]         laneOp1,
	output logic [DataW-1:0]         laneOp2,
	output logic [DispW-1:0]         laneDisp
);

	logic [LaneW-1:0] nextLane; // Lane the next memory op goes to
	logic             xfer;     // Handshake completes this edge

	// Stall while the target slot is still full
	assign instReady = !laneBusy[nextLane];
	assign xfer      = instValid && instReady;

	always_comb begin
		laneLoad = '0;
		if (xfer && isMemOp(opCode))
			laneLoad[nextLane] = 1'b1; // Other opcodes are swallowed here
	end

	// Payload lines shared by all lanes
	assign laneOpCode = opCode;
	assign laneOp1    = op1;
	assign laneOp2    = op2;
	assign laneDisp   = disp;

	// Round-robin pointer, moves only on a dispatch
	always_ff @(posedge clk) begin
		if (!rstN) begin
			nextLane <= '0;
		end else if (|laneLoad) begin
			if (nextLane == LaneW'(NumLanes - 1))
				nextLane <= '0; // Wrap
			else
				nextLane <= nextLane + 1'b1;
		end
	end

	// One lane per dispatch
	assert property (@(posedge clk) disable iff (!rstN) $onehot0(laneLoad));

endmodule

`default_nettype wire

//--- memSysPkg.sv
`default_nettype none

package memSysPkg;

	localparam int NumLanes = 4;   // Address-generation lanes
	localparam int LaneW    = 2;   // Lane index width
	localparam int RamWords = 256; // Quadwords in the data RAM
	localparam int RamAw    = 8;   // Word address width
	localparam int WbAw     = 32;  // Byte address on the bus
	localparam int SelW     = 8;   // One select per byte

	// Access unit sequencing
	typedef enum logic [1:0] {
		Idle, // Waiting on the oldest lane
		Bus,  // Wishbone cycle open
		Emit  // LDA/LDAH result goes out
	} busStateT;

endpackage

`default_nettype wire

//--- alphaIsaPkg.sv
`default_nettype none

package alphaIsaPkg;

	localparam int DataW = 64; // Register and memory quadword
	localparam int LongW = 32; // Longword half of a quad
	localparam int DispW = 16; // Memory-format displacement field
	localparam int OpW   = 6;  // Major opcode field

	// Major opcodes of the memory format
	typedef enum logic [OpW-1:0] {
		OpLda  = 6'h08, // Address only
		OpLdah = 6'h09, // Address only, disp scaled by 64K
		OpLdqU = 6'h0B,
		OpStqU = 6'h0F,
		OpLdl  = 6'h28,
		OpLdq  = 6'h29,
		OpStl  = 6'h2C,
		OpStq  = 6'h2D
	} opCodeT;

	// Everything the memory stage keeps
	function automatic logic isMemOp(input opCodeT op);
		return op inside {OpLda, OpLdah, OpLdqU, OpStqU, OpLdl, OpLdq, OpStl, OpStq};
	endfunction

	// Writes to the RAM, never a result
	function automatic logic isStore(input opCodeT op);
		return op inside {OpStqU, OpStl, OpStq};
	endfunction

	// Result is the computed address itself
	function automatic logic isAddrOnly(input opCodeT op);
		return op inside {OpLda, OpLdah};
	endfunction

	// 32-bit access, half picked by address bit 2
	function automatic logic isLong(input opCodeT op);
		return op inside {OpLdl, OpStl};
	endfunction

endpackage

`default_nettype wire
